//--- pipe_pkg.sv
/*
 * Operand size codes, decode field widths and the operand union
 * used by the memory read stage and its pipeline register
 */
`default_nettype none

package pipe_pkg;

    // Operand size code from decode
    typedef logic [2:0] op_size_t;

    localparam op_size_t SIZE_NONE = 3'd0;
    localparam op_size_t SIZE_8    = 3'd1;
    localparam op_size_t SIZE_16   = 3'd2;
    localparam op_size_t SIZE_32   = 3'd3;
    localparam op_size_t SIZE_48   = 3'd4;
    localparam op_size_t SIZE_64   = 3'd5;
    // Codes 6 and 7 give zero data

    // Decode field widths
    localparam int REG_W    = 3;    // Register number
    localparam int IMM_W    = 48;
    localparam int ALU_OP_W = 4;
    localparam int PC_W     = 32;
    localparam int OPCODE_W = 16;

    // Operand word, seen as a register value or as a memory address
    typedef union packed {
        logic [63:0] value;
        struct packed {
            logic [31:0] unused;
            logic [31:0] address;
        } mem;
    } operand_t;

    // Everything carried by the pipeline register toward execute
    localparam int STAGE_W = $bits(op_size_t)     // Size
                           + 2 * $bits(operand_t) // Operand a and b
                           + REG_W                // Operand a register
                           + 32                   // Operand a address view
                           + 1                    // Operand a is address
                           + IMM_W
                           + ALU_OP_W
                           + PC_W
                           + OPCODE_W;

endpackage

`default_nettype wire

//--- dcache_pkg.sv
/*
 * Data cache widths, dependency table depth and
 * state codes of the cache read sequencer
 */
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 64;
    localparam int DEP_DEPTH = 4;  // Pending store addresses
    localparam int DEP_PTR_W = (DEP_DEPTH > 1) ? $clog2(DEP_DEPTH) : 1;

    // Read sequencer states
    localparam int FSM_W = 3;
    localparam logic [FSM_W-1:0] ST_IDLE  = 3'd0;
    localparam logic [FSM_W-1:0] ST_REQ0  = 3'd1;
    localparam logic [FSM_W-1:0] ST_WAIT0 = 3'd2;
    localparam logic [FSM_W-1:0] ST_REQ1  = 3'd3;
    localparam logic [FSM_W-1:0] ST_WAIT1 = 3'd4;
    localparam logic [FSM_W-1:0] ST_DONE  = 3'd5;

endpackage

`default_nettype wire

//--- pipestage.sv
/*
 * Single entry valid/ready pipeline register with flush
 */
`timescale 1ns/10ps
`default_nettype none

module pipestage #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             flush,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    // Room when empty or being drained this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Payload only moves on a transfer, held while stalled
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- dcache_interface.sv
/*
 * Cache read sequencer for the address operands of one instruction,
 * with size masking of the returned data
 */
`timescale 1ns/10ps
`default_nettype none

module dcache_interface (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          flush,
    input  logic                          start,
    input  logic                          accept,
    input  pipe_pkg::operand_t            op0,
    input  pipe_pkg::operand_t            op1,
    input  logic                          op0_is_address,
    input  logic                          op1_is_address,
    input  pipe_pkg::op_size_t            size,
    output logic                          fetch_done,
    output logic [dcache_pkg::DATA_W-1:0] data0,
    output logic [dcache_pkg::DATA_W-1:0] data1,
    output logic                          rd_req_valid,
    output logic [dcache_pkg::ADDR_W-1:0] rd_req_address,
    output logic                          rd_dp_ready,
    input  logic                          rd_req_ready,
    input  logic                          rd_dp_valid,
    input  logic [dcache_pkg::DATA_W-1:0] rd_dp_read_data
);

    import pipe_pkg::*;
    import dcache_pkg::*;

    logic [FSM_W-1:0]  state;
    logic [FSM_W-1:0]  state_next;
    logic              waiting;
    logic              stale;    // Owed response of a flushed request
    logic [DATA_W-1:0] masked;

    // Keep only the bytes of the operand size
    function automatic logic [DATA_W-1:0] size_mask(
        input logic [DATA_W-1:0] data,
        input op_size_t          sz
    );
        case (sz)
            SIZE_NONE: size_mask = '0;
            SIZE_8:    size_mask = {{(DATA_W - 8){1'b0}}, data[7:0]};
            SIZE_16:   size_mask = {{(DATA_W - 16){1'b0}}, data[15:0]};
            SIZE_32:   size_mask = {{(DATA_W - 32){1'b0}}, data[31:0]};
            SIZE_48:   size_mask = {{(DATA_W - 48){1'b0}}, data[47:0]};
            SIZE_64:   size_mask = data;
            default:   size_mask = '0;
        endcase
    endfunction

    assign masked  = size_mask(rd_dp_read_data, size);
    assign waiting = (state == ST_WAIT0) || (state == ST_WAIT1);

    assign rd_req_valid   = (state == ST_REQ0) || (state == ST_REQ1);
    assign rd_req_address = (state == ST_REQ1) ? op1.mem.address : op0.mem.address;
    assign rd_dp_ready    = waiting || stale;

    // Nothing to fetch counts as done right away
    assign fetch_done = (state == ST_DONE)
                     || (state == ST_IDLE && !op0_is_address && !op1_is_address);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start && !stale) begin
                    if (op0_is_address) begin
                        state_next = ST_REQ0;
                    end else if (op1_is_address) begin
                        state_next = ST_REQ1;
                    end
                end
            end
            ST_REQ0: begin
                if (rd_req_ready) begin
                    state_next = ST_WAIT0;
                end
            end
            ST_WAIT0: begin
                if (rd_dp_valid) begin
                    state_next = op1_is_address ? ST_REQ1 : ST_DONE;
                end
            end
            ST_REQ1: begin
                if (rd_req_ready) begin
                    state_next = ST_WAIT1;
                end
            end
            ST_WAIT1: begin
                if (rd_dp_valid) begin
                    state_next = ST_DONE;
                end
            end
            ST_DONE: begin
                if (accept) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
            stale <= 1'b0;
        end else if (flush) begin
            state <= ST_IDLE;
            // A request already taken by the cache still gets an answer
            stale <= ((stale || waiting) && !rd_dp_valid)
                  || (rd_req_valid && rd_req_ready);
        end else begin
            state <= state_next;
            if (stale && rd_dp_valid) begin
                stale <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_WAIT0 && rd_dp_valid) begin
            data0 <= masked;
        end
        if (state == ST_WAIT1 && rd_dp_valid) begin
            data1 <= masked;
        end
    end

endmodule

`default_nettype wire

//--- address_dependency_table.sv
/*
 * FIFO of store addresses still in flight, with two compare ports
 */
`timescale 1ns/10ps
`default_nettype none

module address_dependency_table (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          flush,
    input  logic                          push,
    input  logic                          pop,
    input  logic [dcache_pkg::ADDR_W-1:0] push_address,
    input  logic [dcache_pkg::ADDR_W-1:0] compare_address_0,
    input  logic [dcache_pkg::ADDR_W-1:0] compare_address_1,
    output logic                          hit_0,
    output logic                          hit_1,
    output logic                          full
);

    import dcache_pkg::*;

    logic [DEP_DEPTH-1:0] entry_valid;
    logic [ADDR_W-1:0]    entry_address [DEP_DEPTH];
    logic [DEP_PTR_W-1:0] head;          // Oldest store
    logic [DEP_PTR_W-1:0] tail;          // Next free slot
    logic                 do_push;
    logic                 do_pop;

    // Wraps for any depth, not only powers of two
    function automatic logic [DEP_PTR_W-1:0] ptr_next(input logic [DEP_PTR_W-1:0] ptr);
        if (ptr == DEP_PTR_W'(DEP_DEPTH - 1)) begin
            ptr_next = '0;
        end else begin
            ptr_next = ptr + 1'b1;
        end
    endfunction

    assign full    = entry_valid[tail];
    assign do_push = push && !full;
    assign do_pop  = pop && entry_valid[head]; // Empty pop dropped

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            entry_valid <= '0;
            head        <= '0;
            tail        <= '0;
        end else if (flush) begin
            entry_valid <= '0;
            head        <= '0;
            tail        <= '0;
        end else begin
            if (do_push) begin
                entry_valid[tail] <= 1'b1;
                tail              <= ptr_next(tail);
            end
            if (do_pop) begin
                entry_valid[head] <= 1'b0;
                head              <= ptr_next(head);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entry_address[tail] <= push_address;
        end
    end

    // Any valid entry matching the compare address
    always_comb begin
        hit_0 = 1'b0;
        hit_1 = 1'b0;
        for (int i = 0; i < DEP_DEPTH; i++) begin
            if (entry_valid[i] && entry_address[i] == compare_address_0) begin
                hit_0 = 1'b1;
            end
            if (entry_valid[i] && entry_address[i] == compare_address_1) begin
                hit_1 = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- memory_read_top.sv
/*
 * Memory read stage: cache operand fetch, store hazard hold
 * and the pipeline register toward execute
 */
`timescale 1ns/10ps
`default_nettype none

module memory_read_top (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            flush,
    input  logic                            wb_valid,
    input  logic                            wb_ready,
    input  logic                            wb_to_memory,
    input  logic                            a_valid,
    output logic                            a_ready,
    input  pipe_pkg::op_size_t              a_size,
    input  pipe_pkg::operand_t              a_op0,
    input  pipe_pkg::operand_t              a_op1,
    input  logic [pipe_pkg::REG_W-1:0]      a_op0_reg,
    input  logic                            a_op0_is_address,
    input  logic                            a_op1_is_address,
    input  logic [pipe_pkg::IMM_W-1:0]      a_imm,
    input  logic [pipe_pkg::ALU_OP_W-1:0]   a_alu_op,
    input  logic [pipe_pkg::PC_W-1:0]       a_pc,
    input  logic [pipe_pkg::OPCODE_W-1:0]   a_opcode,
    output logic                            e_valid,
    input  logic                            e_ready,
    output pipe_pkg::op_size_t              e_size,
    output pipe_pkg::operand_t              e_op_a,
    output pipe_pkg::operand_t              e_op_b,
    output logic [pipe_pkg::REG_W-1:0]      e_op_a_reg,
    output logic [dcache_pkg::ADDR_W-1:0]   e_op_a_address,
    output logic                            e_op_a_is_address,
    output logic [pipe_pkg::IMM_W-1:0]      e_imm,
    output logic [pipe_pkg::ALU_OP_W-1:0]   e_alu_op,
    output logic [pipe_pkg::PC_W-1:0]       e_pc,
    output logic [pipe_pkg::OPCODE_W-1:0]   e_opcode,
    output logic                            rd_req_valid,
    output logic [dcache_pkg::ADDR_W-1:0]   rd_req_address,
    output logic                            rd_dp_ready,
    input  logic                            rd_req_ready,
    input  logic                            rd_dp_valid,
    input  logic [dcache_pkg::DATA_W-1:0]   rd_dp_read_data
);

    import pipe_pkg::*;
    import dcache_pkg::*;

    logic               hit_0;
    logic               hit_1;
    logic               table_full;
    logic               hazard;
    logic               fetch_done;
    logic               stage_ready;
    logic               accept;
    logic               push;
    logic               pop;
    logic [DATA_W-1:0]  data0;
    logic [DATA_W-1:0]  data1;
    operand_t           p_op_a;
    operand_t           p_op_b;
    logic [STAGE_W-1:0] stage_in;
    logic [STAGE_W-1:0] stage_out;

    // Hold any read of an address a store in flight will write
    assign hazard = (hit_0 && a_op0_is_address) || (hit_1 && a_op1_is_address);

    assign accept = a_valid && !hazard && fetch_done && stage_ready && !flush
                 && !(a_op0_is_address && table_full);
    assign a_ready = accept;

    // Push at acceptance so a younger read already sees this store
    assign push = accept && a_op0_is_address;
    assign pop  = wb_valid && wb_ready && wb_to_memory;

    assign p_op_a = a_op0_is_address ? data0 : a_op0.value;
    assign p_op_b = a_op1_is_address ? data1 : a_op1.value;

    assign stage_in = {a_size, p_op_a, p_op_b, a_op0_reg, a_op0.mem.address,
                       a_op0_is_address, a_imm, a_alu_op, a_pc, a_opcode};

    assign {e_size, e_op_a, e_op_b, e_op_a_reg, e_op_a_address,
            e_op_a_is_address, e_imm, e_alu_op, e_pc, e_opcode} = stage_out;

    dcache_interface u_dcache_interface (
        .clk             (clk),
        .arst_n          (arst_n),
        .flush           (flush),
        .start           (a_valid && !hazard),
        .accept          (accept),
        .op0             (a_op0),
        .op1             (a_op1),
        .op0_is_address  (a_op0_is_address),
        .op1_is_address  (a_op1_is_address),
        .size            (a_size),
        .fetch_done      (fetch_done),
        .data0           (data0),
        .data1           (data1),
        .rd_req_valid    (rd_req_valid),
        .rd_req_address  (rd_req_address),
        .rd_dp_ready     (rd_dp_ready),
        .rd_req_ready    (rd_req_ready),
        .rd_dp_valid     (rd_dp_valid),
        .rd_dp_read_data (rd_dp_read_data)
    );

    address_dependency_table u_dep_table (
        .clk               (clk),
        .arst_n            (arst_n),
        .flush             (flush),
        .push              (push),
        .pop               (pop),
        .push_address      (a_op0.mem.address),
        .compare_address_0 (a_op0.mem.address),
        .compare_address_1 (a_op1.mem.address),
        .hit_0             (hit_0),
        .hit_1             (hit_1),
        .full              (table_full)
    );

    pipestage #(
        .WIDTH (STAGE_W)
    ) u_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .in_valid  (accept),
        .in_ready  (stage_ready),
        .in_data   (stage_in),
        .out_valid (e_valid),
        .out_ready (e_ready),
        .out_data  (stage_out)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
/*
 * Testbench clock of 4 ns period and a reset held for two cycles
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
    end

    always #2 clk = ~clk;

endmodule

`default_nettype wire

//--- tb_dcache_model.sv
/*
 * Data cache responder with a random request delay, an address based
 * data pattern and a log of the request addresses in arrival order
 */
`timescale 1ns/10ps
`default_nettype none

module tb_dcache_model (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          rd_req_valid,
    input  logic [dcache_pkg::ADDR_W-1:0] rd_req_address,
    output logic                          rd_req_ready,
    output logic                          rd_dp_valid,
    output logic [dcache_pkg::DATA_W-1:0] rd_dp_read_data,
    input  logic                          rd_dp_ready
);

    localparam logic [63:0] PATTERN_KEY = 64'hA5C3_96F0_0F69_3C5A;

    int          seed = 7;
    int          wait_cnt;
    logic [31:0] addr_log [$];   // Request addresses, oldest first

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_req_ready    <= 1'b0;
            rd_dp_valid     <= 1'b0;
            rd_dp_read_data <= '0;
            wait_cnt        <= 0;
        end else begin
            if (rd_dp_valid && rd_dp_ready) begin
                rd_dp_valid <= 1'b0;
            end
            if (rd_req_valid && rd_req_ready) begin
                rd_req_ready    <= 1'b0;
                addr_log.push_back(rd_req_address);
                rd_dp_valid     <= 1'b1;
                rd_dp_read_data <= {rd_req_address, rd_req_address} ^ PATTERN_KEY;
            end else if (!rd_req_valid) begin
                rd_req_ready <= 1'b0;                 // Request withdrawn by a flush
                wait_cnt     <= $random(seed) & 3;    // Delay of 0 to 3 cycles
            end else if (!rd_dp_valid) begin
                if (wait_cnt == 0) begin
                    rd_req_ready <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- memory_read_tb.sv
/*
 * Directed tests of the memory read stage, compare tasks
 * and the closing error summary
 */
`timescale 1ns/10ps
`default_nettype none

module memory_read_tb;

    import pipe_pkg::*;
    import dcache_pkg::*;

    localparam int TIMEOUT = 60;

    logic clk;
    logic arst_n;
    logic flush, wb_valid, wb_ready, wb_to_memory;
    logic a_valid, a_ready, a_op0_is_address, a_op1_is_address;
    op_size_t a_size, e_size;
    operand_t a_op0, a_op1, e_op_a, e_op_b;
    logic [REG_W-1:0] a_op0_reg, e_op_a_reg;
    logic [IMM_W-1:0] a_imm, e_imm;
    logic [ALU_OP_W-1:0] a_alu_op, e_alu_op;
    logic [PC_W-1:0] a_pc, e_pc;
    logic [OPCODE_W-1:0] a_opcode, e_opcode;
    logic e_valid, e_ready, e_op_a_is_address;
    logic [ADDR_W-1:0] e_op_a_address, rd_req_address;
    logic rd_req_valid, rd_dp_ready, rd_req_ready, rd_dp_valid;
    logic [DATA_W-1:0] rd_dp_read_data;
    int errors = 0;
    int seed = 7;

    tb_clock_gen u_clock (.clk(clk), .arst_n(arst_n));

    memory_read_top dut (.*);

    tb_dcache_model u_cache (
        .clk(clk), .arst_n(arst_n), .rd_req_valid(rd_req_valid),
        .rd_req_address(rd_req_address), .rd_req_ready(rd_req_ready),
        .rd_dp_valid(rd_dp_valid), .rd_dp_read_data(rd_dp_read_data),
        .rd_dp_ready(rd_dp_ready)
    );

    // Cache word for an address, trimmed to the operand size
    function automatic operand_t expected_read(input logic [31:0] addr, input op_size_t size);
        logic [63:0] word;
        int          nbits;
        word = {addr, addr} ^ 64'hA5C3_96F0_0F69_3C5A;
        case (size)
            3'd1: nbits = 8;
            3'd2: nbits = 16;
            3'd3: nbits = 32;
            3'd4: nbits = 48;
            3'd5: nbits = 64;
            default: nbits = 0;
        endcase
        if (nbits == 0) begin
            word = '0;
        end else if (nbits < 64) begin
            word = word & ((64'd1 << nbits) - 64'd1);
        end
        expected_read = word;
    endfunction

    task automatic check_operand(input string name, input operand_t exp, input operand_t act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_address(input string name, input logic [ADDR_W-1:0] exp,
                                 input logic [ADDR_W-1:0] act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    // Present one instruction and hold it until the stage takes it
    task automatic send(input string name, input op_size_t size, input operand_t op0,
                        input operand_t op1, input logic f0, input logic f1,
                        input logic [31:0] pc);
        int   cycles;
        logic done;
        @(posedge clk);
        a_valid <= 1'b1;
        a_size <= size;
        a_op0 <= op0;
        a_op1 <= op1;
        a_op0_is_address <= f0;
        a_op1_is_address <= f1;
        a_pc <= pc;
        a_imm <= {16'h0, pc};
        a_alu_op <= pc[3:0];
        a_opcode <= pc[15:0] ^ 16'h5A5A;
        a_op0_reg <= pc[2:0];
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < TIMEOUT) begin
            @(negedge clk);
            done = a_ready;
            cycles++;
        end
        if (!done) begin
            $display("%s: the stage never accepted the instruction", name);
            errors++;
        end
        @(posedge clk);
        a_valid <= 1'b0;
    endtask

    // Wait for the result at execute and compare it
    task automatic expect_result(input string name, input operand_t exp_a,
                                 input operand_t exp_b, input logic [31:0] exp_pc,
                                 input logic exp_is_addr);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!e_valid && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!e_valid) begin
            $display("%s: no result reached the execute side", name);
            errors++;
        end
        check_operand({name, " op_a"}, exp_a, e_op_a);
        check_operand({name, " op_b"}, exp_b, e_op_b);
        check_address({name, " pc"}, exp_pc, e_pc);
        check_bit({name, " is_address"}, exp_is_addr, e_op_a_is_address);
        @(posedge clk);
    endtask

    task automatic wb_pop();
        @(posedge clk);
        wb_valid <= 1'b1;
        wb_ready <= 1'b1;
        wb_to_memory <= 1'b1;
        @(posedge clk);
        wb_valid <= 1'b0;
        wb_ready <= 1'b0;
        wb_to_memory <= 1'b0;
    endtask

    task automatic test_pass_through();
        int n0;
        n0 = u_cache.addr_log.size();
        send("pass", SIZE_32, 64'h1122_3344_5566_7788, 64'h99AA_BBCC_DDEE_FF00, 0, 0, 32'h16B);
        expect_result("pass", 64'h1122_3344_5566_7788, 64'h99AA_BBCC_DDEE_FF00, 32'h16B, 0);
        check_address("pass address", 32'h5566_7788, e_op_a_address);
        check_operand("pass imm", 64'h16B, operand_t'(64'(e_imm)));
        check_operand("pass opcode", 64'h016B ^ 64'h5A5A, operand_t'(64'(e_opcode)));
        check_operand("pass alu_op", 64'hB, operand_t'(64'(e_alu_op)));
        check_operand("pass reg", 64'h3, operand_t'(64'(e_op_a_reg)));
        check_operand("pass size", 64'(SIZE_32), operand_t'(64'(e_size)));
        check_bit("pass no request", 1'b1, u_cache.addr_log.size() == n0);
    endtask

    task automatic test_size_mask();
        logic [31:0] addr;
        for (int s = 0; s < 8; s++) begin
            addr = 32'h0000_1000 + 32'(s * 16);
            send("size", op_size_t'(s), {32'h0, addr}, 64'h77, 1, 0, 32'h200 + 32'(s));
            expect_result("size", expected_read(addr, op_size_t'(s)), 64'h77,
                          32'h200 + 32'(s), 1);
            wb_pop();
        end
    endtask

    task automatic test_two_operands();
        int n0;
        n0 = u_cache.addr_log.size();
        send("two", SIZE_64, {32'h0, 32'h2000}, {32'h0, 32'h3000}, 1, 1, 32'h300);
        expect_result("two", expected_read(32'h2000, SIZE_64),
                      expected_read(32'h3000, SIZE_64), 32'h300, 1);
        check_bit("two requests", 1'b1, u_cache.addr_log.size() == n0 + 2);
        if (u_cache.addr_log.size() == n0 + 2) begin
            check_address("two first", 32'h2000, u_cache.addr_log[n0]);
            check_address("two second", 32'h3000, u_cache.addr_log[n0 + 1]);
        end
        wb_pop();
    endtask

    task automatic test_dependency();
        send("store", SIZE_64, {32'h0, 32'h4000}, 64'h0, 1, 0, 32'h400);
        expect_result("store", expected_read(32'h4000, SIZE_64), 64'h0, 32'h400, 1);
        fork
            send("held read", SIZE_16, {32'h0, 32'h4000}, 64'h0, 1, 0, 32'h404);
            begin
                repeat (6) begin
                    @(negedge clk);
                    check_bit("held a_ready", 1'b0, a_ready);
                    check_bit("held request", 1'b0, rd_req_valid);
                end
                wb_pop();
            end
        join
        expect_result("held read", expected_read(32'h4000, SIZE_16), 64'h0, 32'h404, 1);
        send("free read", SIZE_32, {32'h0, 32'h5000}, 64'h0, 1, 0, 32'h408);
        expect_result("free read", expected_read(32'h5000, SIZE_32), 64'h0, 32'h408, 1);
        wb_pop();
        wb_pop();
    endtask

    task automatic test_backpressure();
        int             hold;
        int             cycles;
        @(posedge clk);
        e_ready <= 1'b0;
        fork
            for (int i = 0; i < 3; i++) begin
                send("order", SIZE_8, 64'hA0 + 64'(i), 64'h0, 0, 0, 32'h500 + 32'(4 * i));
            end
            for (int i = 0; i < 3; i++) begin
                hold = $random(seed) & 3;
                cycles = 0;
                @(negedge clk);
                while (!e_valid && cycles < TIMEOUT) begin
                    @(negedge clk);
                    cycles++;
                end
                if (!e_valid) begin
                    $display("order: result %0d never arrived", i);
                    errors++;
                end
                repeat (hold) begin
                    @(negedge clk);
                    check_bit("stall valid", 1'b1, e_valid);
                    check_operand("stall op_a", 64'hA0 + 64'(i), e_op_a);
                    check_address("stall pc", 32'h500 + 32'(4 * i), e_pc);
                end
                @(posedge clk);
                e_ready <= 1'b1;
                @(negedge clk);
                check_address("order pc", 32'h500 + 32'(4 * i), e_pc);
                check_operand("order op_a", 64'hA0 + 64'(i), e_op_a);
                @(posedge clk);
                e_ready <= 1'b0;
            end
        join
        @(posedge clk);
        e_ready <= 1'b1;
    endtask

    task automatic test_flush();
        @(posedge clk);
        e_ready <= 1'b0;
        send("flush store", SIZE_64, {32'h0, 32'h6000}, 64'h0, 1, 0, 32'h600);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        check_bit("flush e_valid", 1'b0, e_valid);
        @(posedge clk);
        e_ready <= 1'b1;
        send("after flush", SIZE_48, {32'h0, 32'h6000}, 64'h0, 1, 0, 32'h604);
        expect_result("after flush", expected_read(32'h6000, SIZE_48), 64'h0, 32'h604, 1);
        wb_pop();
    endtask

    initial begin
        flush = 0;
        wb_valid = 0;
        wb_ready = 0;
        wb_to_memory = 0;
        a_valid = 0;
        a_size = SIZE_NONE;
        a_op0 = '0;
        a_op1 = '0;
        a_op0_reg = '0;
        a_op0_is_address = 0;
        a_op1_is_address = 0;
        a_imm = '0;
        a_alu_op = '0;
        a_pc = '0;
        a_opcode = '0;
        e_ready = 1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_bit("reset e_valid", 1'b0, e_valid);
        check_bit("reset rd_req_valid", 1'b0, rd_req_valid);
        check_bit("reset rd_dp_ready", 1'b0, rd_dp_ready);
        check_bit("reset a_ready", 1'b0, a_ready);
        test_pass_through();
        test_size_mask();
        test_two_operands();
        test_dependency();
        test_backpressure();
        test_flush();
        $display("Error count: %0d", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Last guard against a stuck run
    initial begin
        #100000;
        $display("Simulation did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
pipe_pkg.sv
dcache_pkg.sv
pipestage.sv
dcache_interface.sv
address_dependency_table.sv
memory_read_top.sv
tb_clock_gen.sv
tb_dcache_model.sv
memory_read_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the memory read stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module memory_read_tb -o sim_memory_read

./obj_dir/sim_memory_read > sim.log 2>&1
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
    exit 0
fi
exit 1
